// File: all.f
hdl/dmaBusPkg.sv
hdl/busAckIf.sv
hdl/busArbiter.sv
hdl/ackDecoder.sv
hdl/cycleController.sv
hdl/dmaCpuSm.sv
verif/tbClock.sv
verif/dmaCpuSmTb.sv

// File: run.sh
#!/usr/bin/env bash
# builds the dmaCpuSm testbench with Verilator, runs it and scans the log

cd "$(dirname "$0")" || exit 1
logFile=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module dmaCpuSmTb \
    -f all.f -o dmaCpuSmTbSim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/dmaCpuSmTbSim > "$logFile" 2>&1
simStatus=$?
cat "$logFile"

if grep -q "CHECKS FAILED" "$logFile"; then
    echo "simulation reported failure"
    exit 1
fi
if [ $simStatus -ne 0 ]; then
    echo "simulator exited with status $simStatus"
    exit 1
fi
echo "simulation passed"
exit 0

// File: verif/dmaCpuSmTb.sv
// module dmaCpuSmTb with directed bus master tests, slave answers, pulse monitor and watchdog
`timescale 1ns/10ps

module dmaCpuSmTb
    import dmaBusPkg::*;
();

    localparam int clkPeriod    = 40;
    localparam int read32Cycles = 4;
    localparam int read16Pairs  = 2;
    localparam int writeCycles  = 3;
    // bus cycles over all tests plus one each for reset and flush
    localparam int busCycleSum  = 1 + read32Cycles + 2 * read16Pairs + writeCycles + 1;
    localparam int watchdogNs   = busCycleSum * ackTimeout * clkPeriod;

    logic  CLK135;
    logic  CCRESET_;
    logic  dmaEna, dmaDir, fifoEmpty, fifoFull, flushFifo, bgrantN, stermN;
    dsackT dsackN;
    logic  breq, bgack, pas, pds, size1, f2cpuH, f2cpuL, plhw, pllw;
    logic  incFifo, decFifo, incNi, incNo, stopFlush;

    int   incCnt   = 0; // pulse counters kept by the monitor
    int   decCnt   = 0;
    int   stopCnt  = 0;
    int   pasCnt   = 0;
    logic pasPrev  = 1'b0;

    tbClock u_tbClock (
        .CLK135   (CLK135),
        .CCRESET_ (CCRESET_)
    );

    dmaCpuSm u_dmaCpuSm (
        .CLK135    (CLK135),
        .CCRESET_  (CCRESET_),
        .dmaEna    (dmaEna),
        .dmaDir    (dmaDir),
        .fifoEmpty (fifoEmpty),
        .fifoFull  (fifoFull),
        .flushFifo (flushFifo),
        .bgrantN   (bgrantN),
        .dsackN    (dsackN),
        .stermN    (stermN),
        .breq      (breq),
        .bgack     (bgack),
        .pas       (pas),
        .pds       (pds),
        .size1     (size1),
        .f2cpuH    (f2cpuH),
        .f2cpuL    (f2cpuL),
        .plhw      (plhw),
        .pllw      (pllw),
        .incFifo   (incFifo),
        .decFifo   (decFifo),
        .incNi     (incNi),
        .incNo     (incNo),
        .stopFlush (stopFlush)
    );

    task automatic checkEq(input int got, input int want, input string msg);
        if (got !== want) begin
            $display("Mismatch at %0d ns: %s (got %0d, expected %0d)", $time, msg, got, want);
            $display("CHECKS FAILED");
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    // outputs sampled on the falling edge
    always @(negedge CLK135) begin
        checkEq(int'(breq & bgack), 0, "breq and bgack high together");
        incCnt  += int'(incFifo);
        decCnt  += int'(decFifo);
        stopCnt += int'(stopFlush);
        pasCnt  += int'(pas & ~pasPrev);
        pasPrev  = pas;
    end

    task automatic requestBus(input logic dir);
        @(posedge CLK135);
        dmaDir <= dir;
        dmaEna <= 1'b1;
        repeat (3) begin
            @(negedge CLK135);
            checkEq(int'(breq), 0, "breq before the third edge");
        end
        @(negedge CLK135);
        checkEq(int'(breq), 1, "breq on the third edge");
        @(posedge CLK135);
        bgrantN <= 1'b0;
        repeat (3) begin
            @(negedge CLK135);
            checkEq(int'({breq, bgack}), 2, "breq held until the grant is synchronized");
        end
        @(negedge CLK135);
        checkEq(int'({breq, bgack}), 1, "bgack on the third edge after the grant");
        @(posedge CLK135);
        bgrantN <= 1'b1; // arbiter takes the grant away again
    endtask

    // one bus cycle answered by the slave
    // want holds {size1, f2cpuH, f2cpuL, plhw, pllw, inc, dec}
    task automatic busCycle(input dsackT ans, input logic useSterm, input logic [6:0] want,
                            input logic stopAfter);
        int   delay;
        logic sawPds;
        sawPds = 1'b0;
        delay  = $urandom_range(3, 0);
        while (pas !== 1'b1) begin
            @(negedge CLK135);
        end
        checkEq(int'({pds, size1, f2cpuH, f2cpuL}), int'({1'b0, want[6:4]}),
                "address phase pds, size1, f2cpuH, f2cpuL");
        repeat (delay + 1) @(posedge CLK135);
        dsackN <= ans;
        stermN <= ~useSterm;
        if (stopAfter && dmaDir) begin
            fifoEmpty <= 1'b1; // nothing left to write
        end else if (stopAfter) begin
            fifoFull <= 1'b1;  // no room left for reads
        end
        do begin
            @(negedge CLK135);
            sawPds |= pds;
            if (pas) begin
                checkEq(int'({size1, f2cpuH, f2cpuL}), int'(want[6:4]), "held during pas");
            end
        end while (pas);
        checkEq(int'(sawPds), 1, "pds seen during the cycle");
        checkEq(int'({plhw, pllw, incFifo, incNi, decFifo, incNo}),
                int'({want[3:2], want[1], want[1], want[0], want[0]}), "strobes at cycle end");
        @(posedge CLK135);
        dsackN <= 2'b11;
        stermN <= 1'b1;
        @(negedge CLK135);
        checkEq(int'({plhw, pllw, incFifo, incNi, decFifo, incNo}), 0, "strobes one cycle");
        if (stopAfter) begin
            checkEq(int'(bgack), 0, "bgack after the last cycle");
        end
    endtask

    task automatic releaseBus();
        repeat (6) begin
            @(negedge CLK135);
            checkEq(int'({breq, bgack, pas}), 0, "bus idle after the last cycle");
        end
        @(posedge CLK135);
        dmaEna <= 1'b0;
        repeat (syncDepth + 1) @(posedge CLK135);
        fifoFull  <= 1'b0;
        fifoEmpty <= 1'b0;
    endtask

    task automatic resetIdleTest();
        wait (CCRESET_ === 1'b1);
        @(negedge CLK135);
        checkEq(int'({breq, bgack, pas, pds, size1, f2cpuH, f2cpuL, plhw, pllw,
                      incFifo, decFifo, incNi, incNo, stopFlush}), 0, "outputs after reset");
        repeat (20) begin
            @(negedge CLK135);
            checkEq(int'(breq), 0, "breq with dmaEna low");
        end
    endtask

    task automatic read32Test();
        int i;
        int incStart;
        int pasStart;
        incStart = incCnt;
        pasStart = pasCnt;
        requestBus(1'b0);
        for (i = 0; i < read32Cycles; i++) begin
            busCycle(2'b00, 1'b0, 7'b0_00_11_1_0, i == read32Cycles - 1);
        end
        releaseBus();
        checkEq(incCnt - incStart, read32Cycles, "incFifo pulses on 32-bit reads");
        checkEq(pasCnt - pasStart, read32Cycles, "bus cycles on 32-bit reads");
    endtask

    task automatic read16Test();
        int i;
        int incStart;
        int pasStart;
        incStart = incCnt;
        pasStart = pasCnt;
        requestBus(1'b0);
        for (i = 0; i < read16Pairs; i++) begin
            busCycle(2'b01, 1'b0, 7'b0_00_10_0_0, 1'b0);              // high word
            busCycle(2'b01, 1'b0, 7'b1_00_01_1_0, i == read16Pairs - 1); // low word
        end
        releaseBus();
        checkEq(incCnt - incStart, read16Pairs, "incFifo once per 16-bit pair");
        checkEq(pasCnt - pasStart, 2 * read16Pairs, "bus cycles on 16-bit reads");
    endtask

    task automatic writeTest();
        int i;
        int decStart;
        decStart = decCnt;
        requestBus(1'b1);
        for (i = 0; i < writeCycles; i++) begin
            busCycle(2'b11, 1'b1, 7'b0_11_00_0_1, i == writeCycles - 1);
        end
        releaseBus();
        checkEq(decCnt - decStart, writeCycles, "decFifo pulses on STERM writes");
    endtask

    task automatic flushTest();
        int stopStart;
        int pasStart;
        stopStart = stopCnt;
        pasStart  = pasCnt;
        @(posedge CLK135);
        dmaDir    <= 1'b1;
        dmaEna    <= 1'b1;
        fifoEmpty <= 1'b1;
        flushFifo <= 1'b1;
        while (stopFlush !== 1'b1) begin
            @(negedge CLK135);
        end
        repeat (8) begin
            @(negedge CLK135);
            checkEq(int'({breq, bgack, pas}), 0, "bus untouched by the flush");
        end
        checkEq(stopCnt - stopStart, 1, "stopFlush pulses");
        checkEq(pasCnt - pasStart, 0, "bus cycles during the flush");
        @(posedge CLK135);
        flushFifo <= 1'b0;
        dmaEna    <= 1'b0;
    endtask

    initial begin
        #(watchdogNs);
        $display("Timeout: tests still running after %0d ns", watchdogNs);
        $display("CHECKS FAILED");
        $fatal(1, "watchdog expired");
    end

    initial begin
        void'($urandom(86));
        dmaEna    = 1'b0;
        dmaDir    = 1'b0;
        fifoEmpty = 1'b0;
        fifoFull  = 1'b0;
        flushFifo = 1'b0;
        bgrantN   = 1'b1;
        dsackN    = 2'b11;
        stermN    = 1'b1;
        resetIdleTest();
        read32Test();
        read16Test();
        writeTest();
        flushTest();
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

// File: verif/tbClock.sv
// module tbClock: CLK135 at a 40 ns period and a three-cycle CCRESET_ pulse
`timescale 1ns/10ps

module tbClock (
    output logic CLK135,
    output logic CCRESET_
);

    localparam int halfPeriod  = 20;
    localparam int resetCycles = 3;

    initial begin
        CLK135 = 1'b0;
        forever #(halfPeriod) CLK135 = ~CLK135;
    end

    initial begin
        CCRESET_ = 1'b0;
        repeat (resetCycles) @(posedge CLK135);
        CCRESET_ <= 1'b1; // released right after the third edge
    end

endmodule

// File: hdl/dmaCpuSm.sv
// module dmaCpuSm: top level of the CPU-bus master, arbiter, decoder and cycle controller
`timescale 1ns/10ps

module dmaCpuSm
    import dmaBusPkg::*;
(
    input  logic  CLK135,
    input  logic  CCRESET_,
    input  logic  dmaEna,
    input  logic  dmaDir,    // 1 moves FIFO to memory
    input  logic  fifoEmpty,
    input  logic  fifoFull,
    input  logic  flushFifo,
    input  logic  bgrantN,
    input  dsackT dsackN,
    input  logic  stermN,
    output logic  breq,
    output logic  bgack,
    output logic  pas,
    output logic  pds,
    output logic  size1,
    output logic  f2cpuH,
    output logic  f2cpuL,
    output logic  plhw,
    output logic  pllw,
    output logic  incFifo,
    output logic  decFifo,
    output logic  incNi,
    output logic  incNo,
    output logic  stopFlush
);

    logic granted;
    logic needXfer;
    logic flushReq;
    logic cycleEnd;
    logic flushDone;

    busAckIf ackBus ();

    busArbiter u_busArbiter (
        .CLK135    (CLK135),
        .CCRESET_  (CCRESET_),
        .dmaEna    (dmaEna),
        .dmaDir    (dmaDir),
        .fifoEmpty (fifoEmpty),
        .fifoFull  (fifoFull),
        .flushFifo (flushFifo),
        .bgrantN   (bgrantN),
        .cycleEnd  (cycleEnd),
        .flushDone (flushDone),
        .breq      (breq),
        .bgack     (bgack),
        .granted   (granted),
        .needXfer  (needXfer),
        .flushReq  (flushReq)
    );

    ackDecoder u_ackDecoder (
        .CLK135   (CLK135),
        .CCRESET_ (CCRESET_),
        .dsackN   (dsackN),
        .stermN   (stermN),
        .ack      (ackBus.decoder)
    );

    cycleController u_cycleController (
        .CLK135    (CLK135),
        .CCRESET_  (CCRESET_),
        .dmaDir    (dmaDir),
        .fifoEmpty (fifoEmpty),
        .granted   (granted),
        .flushReq  (flushReq),
        .ack       (ackBus.controller),
        .pas       (pas),
        .pds       (pds),
        .size1     (size1),
        .f2cpuH    (f2cpuH),
        .f2cpuL    (f2cpuL),
        .plhw      (plhw),
        .pllw      (pllw),
        .incFifo   (incFifo),
        .decFifo   (decFifo),
        .incNi     (incNi),
        .incNo     (incNo),
        .stopFlush (stopFlush),
        .cycleEnd  (cycleEnd),
        .flushDone (flushDone)
    );

endmodule

// File: hdl/cycleController.sv
// module cycleController: bus cycle FSM, address and data strobes, FIFO and latch strobes
`timescale 1ns/10ps

module cycleController
    import dmaBusPkg::*;
(
    input  logic           CLK135,
    input  logic           CCRESET_,
    input  logic           dmaDir,
    input  logic           fifoEmpty,
    input  logic           granted,
    input  logic           flushReq,
    busAckIf.controller    ack,
    output logic           pas,
    output logic           pds,
    output logic           size1,
    output logic           f2cpuH,
    output logic           f2cpuL,
    output logic           plhw,
    output logic           pllw,
    output logic           incFifo,
    output logic           decFifo,
    output logic           incNi,
    output logic           incNo,
    output logic           stopFlush,
    output logic           cycleEnd,
    output logic           flushDone
);

    cycStateT state;
    logic     halfPending; // low word of a 16-bit transfer still owed
    logic     wide;        // this answer moved the full long word
    logic     lastHalf;    // long word completes with this answer
    logic     flushNow;
    waitCntT  waitCnt;

    assign ack.cycleActive = (state == cWait);
    assign cycleEnd        = (state == cEnd);
    assign flushDone       = stopFlush;

    assign wide     = ack.port32 | ack.syncTerm;
    assign lastHalf = halfPending | wide;

    // nothing left to drain and a flush is asked for
    assign flushNow = flushReq & dmaDir & fifoEmpty & ~stopFlush;

    always_ff @(posedge CLK135 or negedge CCRESET_) begin
        if (!CCRESET_) begin
            state       <= cIdle;
            halfPending <= 1'b0;
            pas         <= 1'b0;
            pds         <= 1'b0;
            size1       <= 1'b0;
            f2cpuH      <= 1'b0;
            f2cpuL      <= 1'b0;
            plhw        <= 1'b0;
            pllw        <= 1'b0;
            incFifo     <= 1'b0;
            decFifo     <= 1'b0;
            incNi       <= 1'b0;
            incNo       <= 1'b0;
            stopFlush   <= 1'b0;
        end else begin
            plhw      <= 1'b0; // single-clock strobes
            pllw      <= 1'b0;
            incFifo   <= 1'b0;
            decFifo   <= 1'b0;
            incNi     <= 1'b0;
            incNo     <= 1'b0;
            stopFlush <= 1'b0;
            case (state)
                cIdle: begin
                    if (flushNow) begin
                        stopFlush <= 1'b1;
                    end else if (granted) begin
                        state <= cAddr;
                    end
                end
                cAddr: begin
                    pas    <= 1'b1;
                    size1  <= halfPending;           // word size for the second half
                    f2cpuH <= dmaDir & ~halfPending;
                    f2cpuL <= dmaDir;
                    state  <= cData;
                end
                cData: begin
                    pds   <= 1'b1;
                    state <= cWait;
                end
                cWait: begin
                    if (ack.ackSeen) begin
                        pas    <= 1'b0;
                        pds    <= 1'b0;
                        size1  <= 1'b0;
                        f2cpuH <= 1'b0;
                        f2cpuL <= 1'b0;
                        if (!dmaDir) begin
                            plhw    <= ~halfPending; // high word comes first
                            pllw    <= lastHalf;
                            incFifo <= lastHalf;
                            incNi   <= lastHalf;
                        end else begin
                            decFifo <= lastHalf;
                            incNo   <= lastHalf;
                        end
                        halfPending <= ~lastHalf;
                        state       <= cEnd;
                    end
                end
                cEnd: begin
                    state <= cIdle;
                end
                default: begin
                    state <= cIdle;
                end
            endcase
        end
    end

    // time spent waiting for the slave
    always_ff @(posedge CLK135 or negedge CCRESET_) begin
        if (!CCRESET_) begin
            waitCnt <= '0;
        end else if (state == cWait) begin
            waitCnt <= waitCnt + 1'b1;
        end else begin
            waitCnt <= '0;
        end
    end

    dataInAddr: assert property (
        @(posedge CLK135) disable iff (!CCRESET_) pds |-> pas
    ) else $error("pds without pas");

    fifoOneWay: assert property (
        @(posedge CLK135) disable iff (!CCRESET_) !(incFifo && decFifo)
    ) else $error("incFifo and decFifo together");

    // slave must answer well before the timeout
    ackInTime: assert property (
        @(posedge CLK135) disable iff (!CCRESET_)
        (state == cWait) |-> (waitCnt < waitCntT'(ackTimeout - 1))
    ) else $error("no acknowledge within ackTimeout cycles");

endmodule

// File: hdl/ackDecoder.sv
// module ackDecoder: samples DSACK and STERM and decodes the port width
`timescale 1ns/10ps

module ackDecoder
    import dmaBusPkg::*;
(
    input  logic           CLK135,
    input  logic           CCRESET_,
    input  dsackT          dsackN,
    input  logic           stermN,
    busAckIf.decoder       ack
);

    logic stermHit;
    logic dsack32;
    logic dsack16;
    logic ackNow;
    logic ackBlock; // one answer per bus cycle

    assign stermHit = ~stermN;
    assign dsack32  = (dsackN == 2'b00);
    assign dsack16  = (dsackN == 2'b01); // DSACK1 low, DSACK0 high

    // DSACK0 alone is no answer, byte ports are not supported
    assign ackNow = ack.cycleActive & ~ackBlock & (stermHit | dsack32 | dsack16);

    always_ff @(posedge CLK135 or negedge CCRESET_) begin
        if (!CCRESET_) begin
            ack.ackSeen <= 1'b0;
            ackBlock    <= 1'b0;
        end else begin
            ack.ackSeen <= ackNow;
            if (ackNow) begin
                ackBlock <= 1'b1;
            end else if (!ack.cycleActive) begin
                ackBlock <= 1'b0; // rearm for the next cycle
            end
        end
    end

    // width info, only looked at together with ackSeen
    always_ff @(posedge CLK135) begin
        if (ackNow) begin
            ack.port32   <= dsack32;
            ack.syncTerm <= stermHit;
        end
    end

    // an answer is only taken inside the controller's wait window
    ackInWindow: assert property (
        @(posedge CLK135) disable iff (!CCRESET_) ack.ackSeen |-> ack.cycleActive
    ) else $error("ackSeen outside of cycleActive");

endmodule

// File: hdl/busArbiter.sv
// module busArbiter: input synchronizers, bus request, grant and release
`timescale 1ns/10ps

module busArbiter
    import dmaBusPkg::*;
(
    input  logic CLK135,
    input  logic CCRESET_,
    input  logic dmaEna,
    input  logic dmaDir,
    input  logic fifoEmpty,
    input  logic fifoFull,
    input  logic flushFifo,
    input  logic bgrantN,
    input  logic cycleEnd,
    input  logic flushDone,
    output logic breq,
    output logic bgack,
    output logic granted,
    output logic needXfer,
    output logic flushReq
);

    logic [2:0] syncPipe [syncDepth]; // each stage is {bgrantN, flushFifo, dmaEna}
    logic dmaEnaS;
    logic flushS;
    logic grantS;
    logic endSeen;      // cycleEnd delayed, fifo flags have settled by then
    logic flushHandled; // flush already answered, wait for flushFifo to drop

    always_ff @(posedge CLK135 or negedge CCRESET_) begin
        if (!CCRESET_) begin
            for (int i = 0; i < syncDepth; i++) begin
                syncPipe[i] <= 3'b100; // grant line idles high
            end
        end else begin
            syncPipe[0] <= {bgrantN, flushFifo, dmaEna};
            for (int i = 1; i < syncDepth; i++) begin
                syncPipe[i] <= syncPipe[i-1];
            end
        end
    end

    assign dmaEnaS = syncPipe[syncDepth-1][0];
    assign flushS  = syncPipe[syncDepth-1][1];
    assign grantS  = ~syncPipe[syncDepth-1][2];

    // room in the direction being moved
    assign needXfer = dmaEnaS & (dmaDir ? ~fifoEmpty : ~fifoFull);
    assign granted  = bgack & needXfer;
    assign flushReq = flushS & ~flushHandled;

    always_ff @(posedge CLK135 or negedge CCRESET_) begin
        if (!CCRESET_) begin
            breq         <= 1'b0;
            bgack        <= 1'b0;
            endSeen      <= 1'b0;
            flushHandled <= 1'b0;
        end else begin
            endSeen <= cycleEnd;
            if (flushDone) begin
                flushHandled <= 1'b1;
            end else if (!flushS) begin
                flushHandled <= 1'b0;
            end
            if (bgack) begin
                if (flushDone || ((cycleEnd || endSeen) && !needXfer)) begin
                    bgack <= 1'b0; // give the bus back
                end
            end else if (breq) begin
                if (grantS) begin
                    breq  <= 1'b0;
                    bgack <= 1'b1; // bus is ours
                end else if (!needXfer) begin
                    breq <= 1'b0; // request withdrawn
                end
            end else if (needXfer) begin
                breq <= 1'b1;
            end
        end
    end

    // request and acknowledge are exclusive on the bus
    reqAckExclusive: assert property (
        @(posedge CLK135) disable iff (!CCRESET_) !(breq && bgack)
    ) else $error("breq and bgack high together");

endmodule

// File: hdl/busAckIf.sv
// interface busAckIf carrying acknowledge information between decoder and controller
`timescale 1ns/10ps

interface busAckIf;

    logic cycleActive; // controller is in its wait window
    logic ackSeen;     // one clock per bus cycle
    logic port32;      // both DSACK lines, valid with ackSeen
    logic syncTerm;    // STERM answer, valid with ackSeen

    modport decoder (
        input  cycleActive,
        output ackSeen,
        output port32,
        output syncTerm
    );

    modport controller (
        output cycleActive,
        input  ackSeen,
        input  port32,
        input  syncTerm
    );

endinterface

// File: hdl/dmaBusPkg.sv
// package with shared localparams, vector typedefs and the cycle state enum
package dmaBusPkg;

    // stages on dmaEna, flushFifo and bgrantN
    localparam int syncDepth = 2;

    // cycles a bus cycle may sit in cWait waiting for an acknowledge
    localparam int ackTimeout = 64;

    // the two active-low acknowledge lines, bit 1 is DSACK1
    typedef logic [1:0] dsackT;

    // wait counter, wide enough to reach ackTimeout - 1
    typedef logic [$clog2(ackTimeout)-1:0] waitCntT;

    // bus cycle sequence of the controller
    typedef enum logic [2:0] {
        cIdle,  // no cycle, flush check
        cAddr,  // address and size out, pas next
        cData,  // pds next
        cWait,  // strobes held, waiting for DSACK or STERM
        cEnd    // strobes pulsed, cycle done
    } cycStateT;

endpackage
